// ==== source/afu_cfg_pkg.sv ====
// Configuration package for the memory test accelerator: sizes, register map and credits
`default_nettype none

package afu_cfg_pkg;

    // ==================================================================
    // Sizes
    // ==================================================================

    // One engine per local memory bank
    localparam int unsigned NUM_ENGINES = 2;
    localparam int unsigned MEM_ADDR_WIDTH = 12;
    localparam int unsigned DATA_WIDTH = 64;
    localparam int unsigned MMIO_ADDR_WIDTH = 8;

    // A length must be able to cover the whole bank, so it takes one bit more than an address
    localparam int unsigned LEN_WIDTH = MEM_ADDR_WIDTH + 1;

    // ==================================================================
    // Register map, in MMIO word addresses
    // ==================================================================

    localparam int unsigned CSR_TEST_ID_LO = 0;
    localparam int unsigned CSR_TEST_ID_HI = 1;
    localparam int unsigned CSR_NUM_ENGINES = 2;

    // Engine e owns the window starting at ENG_CSR_BASE + e * ENG_CSR_STRIDE
    localparam int unsigned ENG_CSR_BASE = 16;
    localparam int unsigned ENG_CSR_STRIDE = 8;
    localparam int unsigned ENG_OFS_BITS = $clog2(ENG_CSR_STRIDE);

    // Offsets inside one engine window
    localparam int unsigned ENG_OFS_CTRL = 0;
    localparam int unsigned ENG_OFS_SEED = 1;
    localparam int unsigned ENG_OFS_STATUS = 2;
    localparam int unsigned ENG_OFS_ERR_COUNT = 3;
    localparam int unsigned ENG_OFS_FIRST_ERR = 4;

    // Status word carries the state in its low bits and done at this position
    localparam int unsigned STATUS_DONE_BIT = 8;

    // The two halves of the 128-bit test identifier
    localparam logic [63:0] TEST_ID_LO = 64'h3c91_e5a2_07d4_b618;
    localparam logic [63:0] TEST_ID_HI = 64'h9f20_4b7e_c351_a08d;

    // ==================================================================
    // Memory flow control
    // ==================================================================

    // Credits each engine holds after reset, one per request that may be in flight
    localparam int unsigned MEM_CREDITS = 4;
    localparam int unsigned CREDIT_WIDTH = $clog2(MEM_CREDITS + 1);

endpackage

`default_nettype wire

// ==== source/engine_pkg.sv ====
// Engine package with the sequencer state and the memory request opcode
`default_nettype none

package engine_pkg;

    // Sequencer state of one test engine
    // The encoding is visible to the host through the status register
    typedef enum logic [2:0]
    {
        ENG_IDLE  = 3'd0,
        // Write the pattern over addresses 0 to len-1
        ENG_WRITE = 3'd1,
        // Read the same addresses back
        ENG_READ  = 3'd2,
        // Wait for outstanding credits and read responses
        ENG_DRAIN = 3'd3,
        ENG_DONE  = 3'd4
    } eng_state_t;

    // Opcode of one request toward the memory bank
    typedef enum logic
    {
        MEM_OP_WRITE = 1'b0,
        MEM_OP_READ  = 1'b1
    } mem_op_t;

endpackage

`default_nettype wire

// ==== source/mem_rsp_check.sv ====
// Response checker that predicts each read word, compares it and keeps error statistics
`default_nettype none
`timescale 1ns/1ps

module mem_rsp_check
(
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic clear,
    input  wire logic [afu_cfg_pkg::DATA_WIDTH-1:0] seed,
    input  wire logic mem_rd_valid,
    input  wire logic [afu_cfg_pkg::DATA_WIDTH-1:0] mem_rd_data,
    output logic [afu_cfg_pkg::LEN_WIDTH-1:0] rsp_count,
    output logic [afu_cfg_pkg::LEN_WIDTH-1:0] err_count,
    output logic [afu_cfg_pkg::MEM_ADDR_WIDTH-1:0] first_err_addr
);
    import afu_cfg_pkg::*;

    logic [MEM_ADDR_WIDTH-1:0] exp_addr;
    logic [DATA_WIDTH-1:0] exp_data;
    logic mismatch;
    logic err_seen;

    // Responses come back in request order, so a local counter names the address
    assign exp_data = seed + DATA_WIDTH'(exp_addr);
    assign mismatch = mem_rd_valid && (mem_rd_data != exp_data);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            exp_addr <= '0;
            rsp_count <= '0;
            err_count <= '0;
            first_err_addr <= '0;
            err_seen <= 1'b0;
        end
        else if (clear)
        begin
            exp_addr <= '0;
            rsp_count <= '0;
            err_count <= '0;
            first_err_addr <= '0;
            err_seen <= 1'b0;
        end
        else
        begin
            if (mem_rd_valid)
            begin
                exp_addr <= exp_addr + 1'b1;
                rsp_count <= rsp_count + 1'b1;
            end
            // Only the first bad address of a run is kept
            if (mismatch)
            begin
                err_count <= err_count + 1'b1;
                if (!err_seen)
                begin
                    err_seen <= 1'b1;
                    first_err_addr <= exp_addr;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/csr_mgr.sv ====
// MMIO register manager that decodes global and per-engine registers and returns read data
`default_nettype none
`timescale 1ns/1ps

module csr_mgr
(
    input  wire logic clk,
    input  wire logic arst_n,

    // Host register port, never stalls
    input  wire logic mmio_write,
    input  wire logic mmio_read,
    input  wire logic [afu_cfg_pkg::MMIO_ADDR_WIDTH-1:0] mmio_address,
    input  wire logic [afu_cfg_pkg::DATA_WIDTH-1:0] mmio_writedata,
    output logic mmio_readdatavalid,
    output logic [afu_cfg_pkg::DATA_WIDTH-1:0] mmio_readdata,

    // Status coming back from the engines
    input  wire engine_pkg::eng_state_t [afu_cfg_pkg::NUM_ENGINES-1:0] eng_state,
    input  wire logic [afu_cfg_pkg::NUM_ENGINES-1:0] eng_done,
    input  wire logic [afu_cfg_pkg::NUM_ENGINES-1:0][afu_cfg_pkg::LEN_WIDTH-1:0] eng_err_count,
    input  wire logic [afu_cfg_pkg::NUM_ENGINES-1:0][afu_cfg_pkg::MEM_ADDR_WIDTH-1:0]
        eng_first_err_addr,

    // Control toward the engines
    output logic [afu_cfg_pkg::NUM_ENGINES-1:0] eng_start,
    output logic [afu_cfg_pkg::NUM_ENGINES-1:0][afu_cfg_pkg::LEN_WIDTH-1:0] eng_len,
    output logic [afu_cfg_pkg::NUM_ENGINES-1:0][afu_cfg_pkg::DATA_WIDTH-1:0] eng_seed
);
    import afu_cfg_pkg::*;

    logic [MMIO_ADDR_WIDTH-1:0] eng_rel;
    logic [MMIO_ADDR_WIDTH-ENG_OFS_BITS-1:0] eng_idx;
    logic [ENG_OFS_BITS-1:0] eng_ofs;
    logic [NUM_ENGINES-1:0] eng_sel;
    logic [DATA_WIDTH-1:0] rd_word;

    // ==================================================================
    // Address decode
    // ==================================================================

    // Split the address relative to the engine region into window and offset
    assign eng_rel = mmio_address - MMIO_ADDR_WIDTH'(ENG_CSR_BASE);
    assign eng_idx = eng_rel[MMIO_ADDR_WIDTH-1:ENG_OFS_BITS];
    assign eng_ofs = eng_rel[ENG_OFS_BITS-1:0];

    // One select per engine, only above the global region
    always_comb
    begin
        for (int e = 0; e < NUM_ENGINES; e++)
        begin
            eng_sel[e] = (mmio_address >= MMIO_ADDR_WIDTH'(ENG_CSR_BASE)) && (int'(eng_idx) == e);
        end
    end

    // ==================================================================
    // Writes
    // ==================================================================

    // A control write loads the length and raises start on the following cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            eng_start <= '0;
            eng_len <= '0;
            eng_seed <= '0;
        end
        else
        begin
            eng_start <= '0;
            for (int e = 0; e < NUM_ENGINES; e++)
            begin
                if (mmio_write && eng_sel[e])
                begin
                    if (eng_ofs == ENG_OFS_BITS'(ENG_OFS_CTRL))
                    begin
                        eng_len[e] <= mmio_writedata[LEN_WIDTH-1:0];
                        eng_start[e] <= 1'b1;
                    end
                    else if (eng_ofs == ENG_OFS_BITS'(ENG_OFS_SEED))
                    begin
                        eng_seed[e] <= mmio_writedata;
                    end
                end
            end
        end
    end

    // ==================================================================
    // Reads
    // ==================================================================

    // Read mux; anything not decoded returns zero
    always_comb
    begin
        rd_word = '0;
        if (mmio_address == MMIO_ADDR_WIDTH'(CSR_TEST_ID_LO))
            rd_word = TEST_ID_LO;
        else if (mmio_address == MMIO_ADDR_WIDTH'(CSR_TEST_ID_HI))
            rd_word = TEST_ID_HI;
        else if (mmio_address == MMIO_ADDR_WIDTH'(CSR_NUM_ENGINES))
            rd_word = DATA_WIDTH'(NUM_ENGINES);

        for (int e = 0; e < NUM_ENGINES; e++)
        begin
            if (eng_sel[e])
            begin
                case (int'(eng_ofs))
                    ENG_OFS_CTRL:      rd_word = DATA_WIDTH'(eng_len[e]);
                    ENG_OFS_SEED:      rd_word = eng_seed[e];
                    ENG_OFS_STATUS:
                    begin
                        rd_word = DATA_WIDTH'(eng_state[e]);
                        rd_word[STATUS_DONE_BIT] = eng_done[e];
                    end
                    ENG_OFS_ERR_COUNT: rd_word = DATA_WIDTH'(eng_err_count[e]);
                    ENG_OFS_FIRST_ERR: rd_word = DATA_WIDTH'(eng_first_err_addr[e]);
                    default:           rd_word = '0;
                endcase
            end
        end
    end

    // Valid follows the read by exactly one cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            mmio_readdatavalid <= 1'b0;
        else
            mmio_readdatavalid <= mmio_read;
    end

    always_ff @(posedge clk)
    begin
        if (mmio_read)
            mmio_readdata <= rd_word;
    end

endmodule

`default_nettype wire

// ==== source/mem_test_engine.sv ====
// Memory test engine that writes a pattern over its bank, reads it back and checks it
`default_nettype none
`timescale 1ns/1ps

module mem_test_engine
(
    input  wire logic clk,
    input  wire logic arst_n,

    // Control from the register manager
    input  wire logic eng_start,
    input  wire logic [afu_cfg_pkg::LEN_WIDTH-1:0] eng_len,
    input  wire logic [afu_cfg_pkg::DATA_WIDTH-1:0] eng_seed,

    // Status back to the register manager
    output engine_pkg::eng_state_t eng_state,
    output logic eng_done,
    output logic [afu_cfg_pkg::LEN_WIDTH-1:0] eng_err_count,
    output logic [afu_cfg_pkg::MEM_ADDR_WIDTH-1:0] eng_first_err_addr,

    // Request stage toward the memory bank
    output logic mem_req_valid,
    output engine_pkg::mem_op_t mem_req_op,
    output logic [afu_cfg_pkg::MEM_ADDR_WIDTH-1:0] mem_req_addr,
    output logic [afu_cfg_pkg::DATA_WIDTH-1:0] mem_req_wdata,

    // Credit return and in-order read responses
    input  wire logic mem_credit_return,
    input  wire logic mem_rd_valid,
    input  wire logic [afu_cfg_pkg::DATA_WIDTH-1:0] mem_rd_data
);
    import afu_cfg_pkg::*;
    import engine_pkg::*;

    eng_state_t state;
    logic [LEN_WIDTH-1:0] len_q;
    logic [DATA_WIDTH-1:0] seed_q;
    logic [LEN_WIDTH-1:0] addr_cnt;
    logic [LEN_WIDTH-1:0] rd_issued;
    logic [LEN_WIDTH-1:0] rsp_count;
    logic [CREDIT_WIDTH-1:0] credit_cnt;
    logic start_ok;
    logic phase_end;
    logic issue;
    logic drained;

    // ==================================================================
    // Sequencer
    // ==================================================================

    // Starts are only taken while idle or done, a busy engine ignores them
    assign start_ok = eng_start && (state == ENG_IDLE || state == ENG_DONE);

    // The address counter has passed the last word of the current phase
    assign phase_end = (addr_cnt == len_q);

    // A request goes out only while a credit is held
    assign issue = (state == ENG_WRITE || state == ENG_READ) && !phase_end &&
                   (credit_cnt != '0);

    // All credits home and every issued read has been checked
    assign drained = (credit_cnt == CREDIT_WIDTH'(MEM_CREDITS)) && (rsp_count == rd_issued);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= ENG_IDLE;
            addr_cnt <= '0;
            rd_issued <= '0;
        end
        else
        begin
            case (state)
                ENG_IDLE, ENG_DONE:
                begin
                    if (start_ok)
                    begin
                        state <= ENG_WRITE;
                        addr_cnt <= '0;
                        rd_issued <= '0;
                    end
                end
                ENG_WRITE:
                begin
                    // Rewind the address for the read phase
                    if (phase_end)
                    begin
                        state <= ENG_READ;
                        addr_cnt <= '0;
                    end
                    else if (issue)
                        addr_cnt <= addr_cnt + 1'b1;
                end
                ENG_READ:
                begin
                    if (phase_end)
                        state <= ENG_DRAIN;
                    else if (issue)
                    begin
                        addr_cnt <= addr_cnt + 1'b1;
                        rd_issued <= rd_issued + 1'b1;
                    end
                end
                ENG_DRAIN:
                begin
                    if (drained)
                        state <= ENG_DONE;
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Length and seed are sampled once so host writes during a run do not disturb it
    always_ff @(posedge clk)
    begin
        if (start_ok)
        begin
            len_q <= eng_len;
            seed_q <= eng_seed;
        end
    end

    // ==================================================================
    // Credit counter
    // ==================================================================

    // Returns add and issues subtract, both in the same cycle cancel out
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            credit_cnt <= CREDIT_WIDTH'(MEM_CREDITS);
        else
        begin
            case ({issue, mem_credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // ==================================================================
    // Request stage and pattern generator
    // ==================================================================

    assign mem_req_valid = issue;
    assign mem_req_op = (state == ENG_READ) ? MEM_OP_READ : MEM_OP_WRITE;
    assign mem_req_addr = addr_cnt[MEM_ADDR_WIDTH-1:0];

    // Pattern word is seed plus address, wrapping at 64 bits
    assign mem_req_wdata = seed_q + DATA_WIDTH'(addr_cnt[MEM_ADDR_WIDTH-1:0]);

    assign eng_state = state;
    assign eng_done = (state == ENG_DONE);

    // Response checker, cleared by every accepted start
    mem_rsp_check mem_rsp_check_i
    (
        .clk            (clk),
        .arst_n         (arst_n),
        .clear          (start_ok),
        .seed           (seed_q),
        .mem_rd_valid   (mem_rd_valid),
        .mem_rd_data    (mem_rd_data),
        .rsp_count      (rsp_count),
        .err_count      (eng_err_count),
        .first_err_addr (eng_first_err_addr)
    );

endmodule

`default_nettype wire

// ==== source/mem_test_afu.sv ====
// Top level of the memory test accelerator with the register manager and one engine per bank
`default_nettype none
`timescale 1ns/1ps

module mem_test_afu
(
    input  wire logic clk,
    input  wire logic arst_n,

    // Host register port
    input  wire logic mmio_write,
    input  wire logic mmio_read,
    input  wire logic [afu_cfg_pkg::MMIO_ADDR_WIDTH-1:0] mmio_address,
    input  wire logic [afu_cfg_pkg::DATA_WIDTH-1:0] mmio_writedata,
    output logic mmio_readdatavalid,
    output logic [afu_cfg_pkg::DATA_WIDTH-1:0] mmio_readdata,

    // Memory banks, one slice per engine
    output logic [afu_cfg_pkg::NUM_ENGINES-1:0] mem_req_valid,
    output engine_pkg::mem_op_t [afu_cfg_pkg::NUM_ENGINES-1:0] mem_req_op,
    output logic [afu_cfg_pkg::NUM_ENGINES-1:0][afu_cfg_pkg::MEM_ADDR_WIDTH-1:0] mem_req_addr,
    output logic [afu_cfg_pkg::NUM_ENGINES-1:0][afu_cfg_pkg::DATA_WIDTH-1:0] mem_req_wdata,
    input  wire logic [afu_cfg_pkg::NUM_ENGINES-1:0] mem_credit_return,
    input  wire logic [afu_cfg_pkg::NUM_ENGINES-1:0] mem_rd_valid,
    input  wire logic [afu_cfg_pkg::NUM_ENGINES-1:0][afu_cfg_pkg::DATA_WIDTH-1:0] mem_rd_data
);
    import afu_cfg_pkg::*;
    import engine_pkg::*;

    // Control and status between the register manager and the engines
    logic [NUM_ENGINES-1:0] eng_start;
    logic [NUM_ENGINES-1:0][LEN_WIDTH-1:0] eng_len;
    logic [NUM_ENGINES-1:0][DATA_WIDTH-1:0] eng_seed;
    eng_state_t [NUM_ENGINES-1:0] eng_state;
    logic [NUM_ENGINES-1:0] eng_done;
    logic [NUM_ENGINES-1:0][LEN_WIDTH-1:0] eng_err_count;
    logic [NUM_ENGINES-1:0][MEM_ADDR_WIDTH-1:0] eng_first_err_addr;

    // ==================================================================
    // Register manager
    // ==================================================================

    csr_mgr csr_mgr_i
    (
        .clk                (clk),
        .arst_n             (arst_n),
        .mmio_write         (mmio_write),
        .mmio_read          (mmio_read),
        .mmio_address       (mmio_address),
        .mmio_writedata     (mmio_writedata),
        .mmio_readdatavalid (mmio_readdatavalid),
        .mmio_readdata      (mmio_readdata),
        .eng_state          (eng_state),
        .eng_done           (eng_done),
        .eng_err_count      (eng_err_count),
        .eng_first_err_addr (eng_first_err_addr),
        .eng_start          (eng_start),
        .eng_len            (eng_len),
        .eng_seed           (eng_seed)
    );

    // ==================================================================
    // Engines, one per local memory bank
    // ==================================================================

    for (genvar e = 0; e < NUM_ENGINES; e++)
    begin : g_eng
        mem_test_engine mem_test_engine_i
        (
            .clk                (clk),
            .arst_n             (arst_n),
            .eng_start          (eng_start[e]),
            .eng_len            (eng_len[e]),
            .eng_seed           (eng_seed[e]),
            .eng_state          (eng_state[e]),
            .eng_done           (eng_done[e]),
            .eng_err_count      (eng_err_count[e]),
            .eng_first_err_addr (eng_first_err_addr[e]),
            .mem_req_valid      (mem_req_valid[e]),
            .mem_req_op         (mem_req_op[e]),
            .mem_req_addr       (mem_req_addr[e]),
            .mem_req_wdata      (mem_req_wdata[e]),
            .mem_credit_return  (mem_credit_return[e]),
            .mem_rd_valid       (mem_rd_valid[e]),
            .mem_rd_data        (mem_rd_data[e])
        );
    end

endmodule

`default_nettype wire

// ==== verif/mem_test_afu_tb.sv ====
// Testbench for the memory test accelerator with bank models, MMIO tasks and pattern checks
`default_nettype none
`timescale 1ns/1ps

module mem_test_afu_tb;
    import afu_cfg_pkg::*;
    import engine_pkg::*;

    // Limits for every wait loop
    localparam int MMIO_TIMEOUT = 16;
    localparam int DONE_POLLS = 2000;
    // Read responses waiting in one bank model
    localparam int RSP_DEPTH = 16;

    logic clk;
    logic arst_n;
    logic mmio_write;
    logic mmio_read;
    logic [MMIO_ADDR_WIDTH-1:0] mmio_address;
    logic [DATA_WIDTH-1:0] mmio_writedata;
    logic mmio_readdatavalid;
    logic [DATA_WIDTH-1:0] mmio_readdata;
    logic [NUM_ENGINES-1:0] mem_req_valid;
    mem_op_t [NUM_ENGINES-1:0] mem_req_op;
    logic [NUM_ENGINES-1:0][MEM_ADDR_WIDTH-1:0] mem_req_addr;
    logic [NUM_ENGINES-1:0][DATA_WIDTH-1:0] mem_req_wdata;
    logic [NUM_ENGINES-1:0] mem_credit_return = '0;
    logic [NUM_ENGINES-1:0] mem_rd_valid = '0;
    logic [NUM_ENGINES-1:0][DATA_WIDTH-1:0] mem_rd_data = '0;

    // Bank model storage and bookkeeping with one slot per bank
    logic [DATA_WIDTH-1:0] bank_mem [NUM_ENGINES][1 << MEM_ADDR_WIDTH];
    logic [MEM_ADDR_WIDTH-1:0] rsp_addr [NUM_ENGINES][RSP_DEPTH];
    int rsp_due [NUM_ENGINES][RSP_DEPTH];
    int rsp_wr [NUM_ENGINES];
    int rsp_rd [NUM_ENGINES];
    int last_due [NUM_ENGINES];
    int credit_pend [NUM_ENGINES];
    int credit_wait [NUM_ENGINES];
    int outstanding [NUM_ENGINES];
    int cycle = 0;
    int due;
    int seed = 32'h672f52ce;
    logic [MEM_ADDR_WIDTH-1:0] ret_addr;
    logic [DATA_WIDTH-1:0] ret_word;

    // Knobs the test sequence turns on and off between runs
    logic hold_credits;
    logic [NUM_ENGINES-1:0] corrupt_en;
    logic [MEM_ADDR_WIDTH-1:0] corrupt_addr [NUM_ENGINES];

    mem_test_afu mem_test_afu_i
    (
        .clk                (clk),
        .arst_n             (arst_n),
        .mmio_write         (mmio_write),
        .mmio_read          (mmio_read),
        .mmio_address       (mmio_address),
        .mmio_writedata     (mmio_writedata),
        .mmio_readdatavalid (mmio_readdatavalid),
        .mmio_readdata      (mmio_readdata),
        .mem_req_valid      (mem_req_valid),
        .mem_req_op         (mem_req_op),
        .mem_req_addr       (mem_req_addr),
        .mem_req_wdata      (mem_req_wdata),
        .mem_credit_return  (mem_credit_return),
        .mem_rd_valid       (mem_rd_valid),
        .mem_rd_data        (mem_rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==================================================================
    // Helpers
    // ==================================================================

    // Expected word at a bank address is the seed plus the address modulo 2^64
    function automatic logic [63:0] pattern_word(input logic [63:0] s, input int addr);
        return s + 64'(addr);
    endfunction

    function automatic logic [MMIO_ADDR_WIDTH-1:0] eng_reg(input int e, input int ofs);
        return MMIO_ADDR_WIDTH'(ENG_CSR_BASE + e * ENG_CSR_STRIDE + ofs);
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected)
            fail_stop($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h",
                                name, expected, actual));
    endtask

    task automatic write_reg(input logic [MMIO_ADDR_WIDTH-1:0] addr, input logic [63:0] data);
        @(posedge clk);
        mmio_write <= 1'b1;
        mmio_address <= addr;
        mmio_writedata <= data;
        @(posedge clk);
        mmio_write <= 1'b0;
    endtask

    // Valid and data are looked at on the falling edge after the read is sampled
    task automatic read_reg(input logic [MMIO_ADDR_WIDTH-1:0] addr, output logic [63:0] data);
        int n;
        @(posedge clk);
        mmio_read <= 1'b1;
        mmio_address <= addr;
        // No read is pending yet so valid is still low
        @(negedge clk);
        check_equal("mmio valid before read", 64'd0, 64'(mmio_readdatavalid));
        @(posedge clk);
        mmio_read <= 1'b0;
        for (n = 0; n < MMIO_TIMEOUT; n++)
        begin
            @(negedge clk);
            if (mmio_readdatavalid)
                break;
        end
        if (n == MMIO_TIMEOUT)
            fail_stop($sformatf("MMIO read of address %0d never returned data", addr));
        // Valid follows the read by exactly one cycle
        check_equal("mmio valid latency", 64'd1, 64'(n + 1));
        data = mmio_readdata;
    endtask

    task automatic start_engine(input int e, input logic [63:0] s, input int len);
        write_reg(eng_reg(e, ENG_OFS_SEED), s);
        write_reg(eng_reg(e, ENG_OFS_CTRL), 64'(len));
    endtask

    // Poll status until the done bit shows up
    task automatic wait_done(input int e);
        logic [63:0] status;
        int polls;
        for (polls = 0; polls < DONE_POLLS; polls++)
        begin
            read_reg(eng_reg(e, ENG_OFS_STATUS), status);
            if (status[STATUS_DONE_BIT])
                break;
        end
        if (polls == DONE_POLLS)
            fail_stop($sformatf("engine %0d did not reach done within the poll limit", e));
    endtask

    // Done status, error count and first error address after a run
    task automatic check_result(input int e, input int errs, input int first_err);
        logic [63:0] rd;
        read_reg(eng_reg(e, ENG_OFS_STATUS), rd);
        check_equal($sformatf("eng%0d status", e),
                    64'(ENG_DONE) | (64'd1 << STATUS_DONE_BIT), rd);
        read_reg(eng_reg(e, ENG_OFS_ERR_COUNT), rd);
        check_equal($sformatf("eng%0d error count", e), 64'(errs), rd);
        read_reg(eng_reg(e, ENG_OFS_FIRST_ERR), rd);
        check_equal($sformatf("eng%0d first error address", e), 64'(first_err), rd);
    endtask

    task automatic check_bank(input int e, input logic [63:0] s, input int len);
        for (int a = 0; a < len; a++)
            check_equal($sformatf("bank%0d word %0d", e, a), pattern_word(s, a), bank_mem[e][a]);
    endtask

    // ==================================================================
    // Bank models
    // ==================================================================

    // Writes retire at once and reads retire when their data goes back
    // Credits trickle back one per cycle and can be held back in long stretches
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        for (int b = 0; b < NUM_ENGINES; b++)
        begin
            mem_rd_valid[b] <= 1'b0;
            mem_credit_return[b] <= 1'b0;
            if (!arst_n)
            begin
                rsp_wr[b] = 0;
                rsp_rd[b] = 0;
                last_due[b] = 0;
                credit_pend[b] = 0;
                credit_wait[b] = 0;
                outstanding[b] = 0;
            end
            else
            begin
                if (mem_req_valid[b])
                begin
                    outstanding[b] = outstanding[b] + 1;
                    if (outstanding[b] > int'(MEM_CREDITS))
                        fail_stop($sformatf("bank %0d got a request with no credit free", b));
                    if (mem_req_op[b] == MEM_OP_WRITE)
                    begin
                        bank_mem[b][mem_req_addr[b]] = mem_req_wdata[b];
                        credit_pend[b] = credit_pend[b] + 1;
                    end
                    else
                    begin
                        // Keep responses in order with at most one per cycle
                        due = cycle + 1 + int'($unsigned($random(seed)) % 4);
                        if (due <= last_due[b])
                            due = last_due[b] + 1;
                        last_due[b] = due;
                        rsp_due[b][rsp_wr[b]] = due;
                        rsp_addr[b][rsp_wr[b]] = mem_req_addr[b];
                        rsp_wr[b] = (rsp_wr[b] + 1) % RSP_DEPTH;
                    end
                end
                if (rsp_rd[b] != rsp_wr[b] && rsp_due[b][rsp_rd[b]] <= cycle)
                begin
                    ret_addr = rsp_addr[b][rsp_rd[b]];
                    ret_word = bank_mem[b][ret_addr];
                    if (corrupt_en[b] && ret_addr == corrupt_addr[b])
                        ret_word = ~ret_word;
                    mem_rd_valid[b] <= 1'b1;
                    mem_rd_data[b] <= ret_word;
                    rsp_rd[b] = (rsp_rd[b] + 1) % RSP_DEPTH;
                    credit_pend[b] = credit_pend[b] + 1;
                end
                if (credit_wait[b] > 0)
                    credit_wait[b] = credit_wait[b] - 1;
                else if (credit_pend[b] > 0 && (!hold_credits || (cycle % 40) >= 32))
                begin
                    mem_credit_return[b] <= 1'b1;
                    credit_pend[b] = credit_pend[b] - 1;
                    outstanding[b] = outstanding[b] - 1;
                    credit_wait[b] = int'($unsigned($random(seed)) % 3);
                end
            end
        end
    end

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial
    begin
        logic [63:0] rd;
        arst_n = 1'b0;
        mmio_write = 1'b0;
        mmio_read = 1'b0;
        mmio_address = '0;
        mmio_writedata = '0;
        hold_credits = 1'b0;
        corrupt_en = '0;
        corrupt_addr[0] = '0;
        corrupt_addr[1] = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // Identifier, engine count, seed readback and holes in the map
        read_reg(MMIO_ADDR_WIDTH'(0), rd);
        check_equal("test id low", TEST_ID_LO, rd);
        read_reg(MMIO_ADDR_WIDTH'(1), rd);
        check_equal("test id high", TEST_ID_HI, rd);
        read_reg(MMIO_ADDR_WIDTH'(2), rd);
        check_equal("engine count", 64'(NUM_ENGINES), rd);
        write_reg(eng_reg(1, ENG_OFS_SEED), 64'h0123_4567_89ab_cdef);
        read_reg(eng_reg(1, ENG_OFS_SEED), rd);
        check_equal("eng1 seed readback", 64'h0123_4567_89ab_cdef, rd);
        read_reg(MMIO_ADDR_WIDTH'(3), rd);
        check_equal("unmapped 3", 64'd0, rd);
        read_reg(eng_reg(0, 5), rd);
        check_equal("unmapped engine offset 5", 64'd0, rd);
        read_reg(MMIO_ADDR_WIDTH'(200), rd);
        check_equal("unmapped 200", 64'd0, rd);

        // Plain run of engine 0
        start_engine(0, 64'h0000_1000_0000_0000, 64);
        wait_done(0);
        check_result(0, 0, 0);
        read_reg(eng_reg(0, ENG_OFS_CTRL), rd);
        check_equal("eng0 length readback", 64'd64, rd);
        check_bank(0, 64'h0000_1000_0000_0000, 64);

        // One bad word on readback with a seed that wraps past 2^64
        corrupt_addr[1] <= MEM_ADDR_WIDTH'(17);
        corrupt_en <= 2'b10;
        start_engine(1, 64'hffff_ffff_ffff_fff0, 32);
        wait_done(1);
        check_result(1, 1, 17);
        check_bank(1, 64'hffff_ffff_ffff_fff0, 32);
        corrupt_en <= '0;

        // Credits held back most of the time
        hold_credits <= 1'b1;
        start_engine(0, 64'h5a5a_0000_0000_0001, 48);
        wait_done(0);
        check_result(0, 0, 0);
        check_bank(0, 64'h5a5a_0000_0000_0001, 48);
        hold_credits <= 1'b0;

        // Both engines together while engine 1 restarts from its earlier error
        start_engine(0, 64'h0bad_cafe_0000_0000, 100);
        start_engine(1, 64'h7777_0000_1234_0000, 77);
        wait_done(0);
        wait_done(1);
        check_result(0, 0, 0);
        check_result(1, 0, 0);
        check_bank(0, 64'h0bad_cafe_0000_0000, 100);
        check_bank(1, 64'h7777_0000_1234_0000, 77);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/afu_cfg_pkg.sv
source/engine_pkg.sv
source/mem_rsp_check.sv
source/csr_mgr.sv
source/mem_test_engine.sv
source/mem_test_afu.sv
verif/mem_test_afu_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory test accelerator testbench

SIM = obj_dir/Vmem_test_afu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module mem_test_afu_tb -f filelist.f -Mdir obj_dir

run: compile
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "sim failed" sim.log; then echo "Result: FAIL"; exit 1; fi
	@if grep -q "sim passed" sim.log; then echo "Result: PASS"; else echo "Result: no verdict"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
